//--- hdl/periph_pkg.sv
package periph_pkg;

  // AHB bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Slot number sits in haddr[SLOT_LSB +: SLOT_W]
  localparam int SLOT_LSB = 16;
  localparam int SLOT_W   = 2;

  typedef enum logic [SLOT_W-1:0] {
    SLOT_NULL0 = 2'd0,
    SLOT_SEG7  = 2'd1,
    SLOT_NULL2 = 2'd2,
    SLOT_NULL3 = 2'd3
  } slot_e;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Display
  localparam int NUM_DIGITS = 8;

  // Seg7 register map, byte offsets inside the slot
  localparam logic [SLOT_LSB-1:0] DIGITS_OFS = 16'h0000; // 8 hex nibbles, digit 0 in [3:0]
  localparam logic [SLOT_LSB-1:0] DP_OFS     = 16'h0004; // Decimal point mask

endpackage

//--- hdl/ahb_if.sv
`timescale 1ns/100ps

interface ahb_if;

  logic                            sel;
  logic [periph_pkg::ADDR_W-1:0]   addr;
  periph_pkg::htrans_e             trans;
  logic [2:0]                      size;
  logic                            write;
  logic [periph_pkg::DATA_W-1:0]   wdata;
  logic                            ready;    // Muxed HREADY back to all slaves

  logic                            readyout;
  logic [periph_pkg::DATA_W-1:0]   rdata;
  logic                            resp;

  modport decoder (
    output sel, addr, trans, size, write, wdata, ready,
    input  readyout, rdata, resp
  );

  modport slave (
    input  sel, addr, trans, size, write, wdata, ready,
    output readyout, rdata, resp
  );

endinterface

//--- hdl/ahb_decoder.sv
`timescale 1ns/100ps

module ahb_decoder (
  input  logic                          CLK_FPGA_SYS1,
  input  logic                          rst_n,
  input  logic                          hsel,
  input  logic [periph_pkg::ADDR_W-1:0] haddr,
  input  periph_pkg::htrans_e           htrans,
  input  logic [2:0]                    hsize,
  input  logic                          hwrite,
  input  logic [periph_pkg::DATA_W-1:0] hwdata,
  output logic [periph_pkg::DATA_W-1:0] hrdata,
  output logic                          hready,
  output logic                          hresp,
  ahb_if.decoder                        slot0,
  ahb_if.decoder                        slot1,
  ahb_if.decoder                        slot2,
  ahb_if.decoder                        slot3
);

  localparam int NUM_SLOTS = 2 ** periph_pkg::SLOT_W;

  periph_pkg::slot_e             addr_slot;
  periph_pkg::slot_e             data_slot;
  logic                          data_act;
  logic [NUM_SLOTS-1:0]          sel_vec;
  logic [NUM_SLOTS-1:0]          readyout_vec;
  logic [NUM_SLOTS-1:0]          resp_vec;
  logic [periph_pkg::DATA_W-1:0] rdata_vec [NUM_SLOTS];

  assign addr_slot = periph_pkg::slot_e'(haddr[periph_pkg::SLOT_LSB +: periph_pkg::SLOT_W]);
  assign sel_vec   = hsel ? (NUM_SLOTS'(1) << addr_slot) : '0;

  // Address phase broadcast
  assign slot0.sel   = sel_vec[0];
  assign slot0.addr  = haddr;
  assign slot0.trans = htrans;
  assign slot0.size  = hsize;
  assign slot0.write = hwrite;
  assign slot0.wdata = hwdata;
  assign slot0.ready = hready;

  assign slot1.sel   = sel_vec[1];
  assign slot1.addr  = haddr;
  assign slot1.trans = htrans;
  assign slot1.size  = hsize;
  assign slot1.write = hwrite;
  assign slot1.wdata = hwdata;
  assign slot1.ready = hready;

  assign slot2.sel   = sel_vec[2];
  assign slot2.addr  = haddr;
  assign slot2.trans = htrans;
  assign slot2.size  = hsize;
  assign slot2.write = hwrite;
  assign slot2.wdata = hwdata;
  assign slot2.ready = hready;

  assign slot3.sel   = sel_vec[3];
  assign slot3.addr  = haddr;
  assign slot3.trans = htrans;
  assign slot3.size  = hsize;
  assign slot3.write = hwrite;
  assign slot3.wdata = hwdata;
  assign slot3.ready = hready;

  assign readyout_vec = {slot3.readyout, slot2.readyout, slot1.readyout, slot0.readyout};
  assign resp_vec     = {slot3.resp, slot2.resp, slot1.resp, slot0.resp};
  assign rdata_vec[0] = slot0.rdata;
  assign rdata_vec[1] = slot1.rdata;
  assign rdata_vec[2] = slot2.rdata;
  assign rdata_vec[3] = slot3.rdata;

  // Data phase slot, follows each accepted address phase
  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_act  <= 1'b0;
      data_slot <= periph_pkg::SLOT_NULL0;
    end
    else if (hready)
    begin
      data_act  <= hsel && (htrans == periph_pkg::NONSEQ || htrans == periph_pkg::SEQ);
      data_slot <= addr_slot;
    end
  end

  assign hready = data_act ? readyout_vec[data_slot] : 1'b1; // Idle data phase is OK
  assign hresp  = data_act & resp_vec[data_slot];
  assign hrdata = data_act ? rdata_vec[data_slot] : '0;

endmodule

//--- hdl/seg7_shifter.sv
`timescale 1ns/100ps

module seg7_shifter #(
  parameter int SCLK_DIV = 4
) (
  input  logic                                CLK_FPGA_SYS1,
  input  logic                                rst_n,
  input  logic [periph_pkg::NUM_DIGITS*4-1:0] digits,
  input  logic [periph_pkg::NUM_DIGITS-1:0]   dp,
  output logic                                seg7_sh_cp,
  output logic                                seg7_st_cp,
  output logic                                seg7_ds
);

  localparam int ND     = periph_pkg::NUM_DIGITS;
  localparam int WORD_W = 8 + ND;  // Segment byte then select byte
  localparam int DIV_W  = $clog2(SCLK_DIV + 1);
  localparam int BIT_W  = $clog2(WORD_W);
  localparam int DIG_W  = $clog2(ND);

  typedef enum logic [1:0] {SHIFT_LOW, SHIFT_HIGH, LATCH} state_e;

  state_e              state;
  logic [DIV_W-1:0]    div_cnt;
  logic                div_end;
  logic [BIT_W-1:0]    bit_cnt;
  logic [DIG_W-1:0]    digit;
  logic [DIG_W-1:0]    digit_nxt;
  logic [WORD_W-1:0]   word;
  logic [WORD_W-1:0]   word_nxt;
  logic                st_cp_q;

  // Segments g..a, active high
  function automatic logic [6:0] hex_seg(input logic [3:0] hex);
    case (hex)
      4'h0: hex_seg = 7'h3F;
      4'h1: hex_seg = 7'h06;
      4'h2: hex_seg = 7'h5B;
      4'h3: hex_seg = 7'h4F;
      4'h4: hex_seg = 7'h66;
      4'h5: hex_seg = 7'h6D;
      4'h6: hex_seg = 7'h7D;
      4'h7: hex_seg = 7'h07;
      4'h8: hex_seg = 7'h7F;
      4'h9: hex_seg = 7'h6F;
      4'hA: hex_seg = 7'h77;
      4'hB: hex_seg = 7'h7C;
      4'hC: hex_seg = 7'h39;
      4'hD: hex_seg = 7'h5E;
      4'hE: hex_seg = 7'h79;
      default: hex_seg = 7'h71;
    endcase
  endfunction

  assign div_end   = (div_cnt == DIV_W'(SCLK_DIV - 1));
  assign digit_nxt = (digit == DIG_W'(ND - 1)) ? '0 : digit + 1'b1;
  assign word_nxt  = {dp[digit_nxt], hex_seg(digits[digit_nxt*4 +: 4]), ND'(1) << digit_nxt};

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= LATCH;                   // Quiet latch, loads digit 0 next
      div_cnt <= DIV_W'(SCLK_DIV - 1);
      bit_cnt <= '0;
      digit   <= DIG_W'(ND - 1);
      word    <= '0;
      st_cp_q <= 1'b0;
    end
    else
    begin
      div_cnt <= div_end ? '0 : div_cnt + 1'b1;
      if (div_end)
      begin
        case (state)
          SHIFT_LOW:
            state <= SHIFT_HIGH;
          SHIFT_HIGH:
            if (bit_cnt == BIT_W'(WORD_W - 1))
            begin
              state   <= LATCH;
              st_cp_q <= 1'b1;
            end
            else
            begin
              state   <= SHIFT_LOW;
              bit_cnt <= bit_cnt + 1'b1;
              word    <= word << 1;       // Next bit while clock falls
            end
          default:
          begin
            state   <= SHIFT_LOW;
            st_cp_q <= 1'b0;
            bit_cnt <= '0;
            digit   <= digit_nxt;
            word    <= word_nxt;
          end
        endcase
      end
    end
  end

  assign seg7_sh_cp = (state == SHIFT_HIGH);
  assign seg7_st_cp = st_cp_q;
  assign seg7_ds    = word[WORD_W-1];   // MSB first

endmodule

//--- hdl/ahb_seg7.sv
`timescale 1ns/100ps

module ahb_seg7 #(
  parameter int SCLK_DIV = 4
) (
  input  logic  CLK_FPGA_SYS1,
  input  logic  rst_n,
  ahb_if.slave  bus,
  output logic  seg7_sh_cp,
  output logic  seg7_st_cp,
  output logic  seg7_ds
);

  localparam int ND  = periph_pkg::NUM_DIGITS;
  localparam int MSB = periph_pkg::SLOT_LSB - 1;

  logic          valid;
  logic [3:0]    be;
  logic          wr_q;
  logic [MSB:2]  ofs_q;
  logic [3:0]    be_q;
  logic [ND*4-1:0] digits_q;
  logic [ND-1:0] dp_q;
  logic          hit_digits;
  logic          hit_dp;

  assign valid = bus.sel && bus.ready &&
                 (bus.trans == periph_pkg::NONSEQ || bus.trans == periph_pkg::SEQ);

  // Byte lanes from size and low address bits
  always_comb
  begin
    case (bus.size)
      3'b000:  be = 4'b0001 << bus.addr[1:0];
      3'b001:  be = bus.addr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;
    endcase
  end

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_q <= 1'b0;
    end
    else if (bus.ready)
    begin
      wr_q <= valid && bus.write;
    end
  end

  always_ff @(posedge CLK_FPGA_SYS1)
  begin
    if (valid)
    begin
      ofs_q <= bus.addr[MSB:2];
      be_q  <= be;
    end
  end

  assign hit_digits = (ofs_q == periph_pkg::DIGITS_OFS[MSB:2]);
  assign hit_dp     = (ofs_q == periph_pkg::DP_OFS[MSB:2]);

  // Write lands at the end of the data phase
  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      digits_q <= '0;
      dp_q     <= '0;
    end
    else if (wr_q)
    begin
      for (int b = 0; b < 4; b++)
        if (hit_digits && be_q[b])
          digits_q[8*b +: 8] <= bus.wdata[8*b +: 8];
      if (hit_dp && be_q[0])
        dp_q <= bus.wdata[ND-1:0];
    end
  end

  always_comb
  begin
    bus.rdata = '0;
    if (hit_digits)
      bus.rdata = digits_q;
    else if (hit_dp)
      bus.rdata[ND-1:0] = dp_q;
  end

  assign bus.readyout = 1'b1; // Zero wait state
  assign bus.resp     = 1'b0;

  seg7_shifter #(
    .SCLK_DIV (SCLK_DIV)
  ) shifter_inst (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .rst_n         (rst_n),
    .digits        (digits_q),
    .dp            (dp_q),
    .seg7_sh_cp    (seg7_sh_cp),
    .seg7_st_cp    (seg7_st_cp),
    .seg7_ds       (seg7_ds)
  );

endmodule

//--- hdl/ahb_null.sv
`timescale 1ns/100ps

module ahb_null (
  input  logic CLK_FPGA_SYS1,
  input  logic rst_n,
  ahb_if.slave bus
);

  typedef enum logic {NULL_IDLE, NULL_ERR} state_e;

  state_e state;
  logic   resp_q;  // Second error cycle
  logic   valid;

  assign valid = bus.sel && bus.ready &&
                 (bus.trans == periph_pkg::NONSEQ || bus.trans == periph_pkg::SEQ);

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= NULL_IDLE;
      resp_q <= 1'b0;
    end
    else
    begin
      resp_q <= (state == NULL_ERR);
      if (state == NULL_ERR)
        state <= NULL_IDLE;
      else if (valid)
        state <= NULL_ERR;
    end
  end

  assign bus.readyout = (state != NULL_ERR);
  assign bus.resp     = (state == NULL_ERR) | resp_q;
  assign bus.rdata    = '0;

endmodule

//--- hdl/led_flow.sv
`timescale 1ns/100ps

module led_flow #(
  parameter int LED_PERIOD = 50_000_000
) (
  input  logic       CLK_FPGA_SYS1,
  input  logic       rst_n,
  output logic [1:0] led
);

  localparam int CNT_W = $clog2(LED_PERIOD + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt <= '0;
      led <= 2'b01;
    end
    else if (cnt == CNT_W'(LED_PERIOD - 1))
    begin
      cnt <= '0;
      led <= {led[0], led[1]};  // Swap the two LEDs
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- hdl/periph_top.sv
`timescale 1ns/100ps

module periph_top #(
  parameter int SCLK_DIV   = 4,
  parameter int LED_PERIOD = 50_000_000
) (
  input  logic                          CLK_FPGA_SYS1,
  input  logic                          arst_n,
  input  logic                          hsel,
  input  logic [periph_pkg::ADDR_W-1:0] haddr,
  input  periph_pkg::htrans_e           htrans,
  input  logic [2:0]                    hsize,
  input  logic                          hwrite,
  input  logic [periph_pkg::DATA_W-1:0] hwdata,
  output logic [periph_pkg::DATA_W-1:0] hrdata,
  output logic                          hready,
  output logic                          hresp,
  output logic                          seg7_sh_cp,
  output logic                          seg7_st_cp,
  output logic                          seg7_ds,
  output logic [1:0]                    led
);

  localparam int NUM_SLOTS = 2 ** periph_pkg::SLOT_W;

  logic rst_meta;
  logic rst_n;

  // Async assert, release after two clocks
  always_ff @(posedge CLK_FPGA_SYS1 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rst_meta <= 1'b0;
      rst_n    <= 1'b0;
    end
    else
    begin
      rst_meta <= 1'b1;
      rst_n    <= rst_meta;
    end
  end

  ahb_if slot_bus [NUM_SLOTS] ();

  ahb_decoder decoder_inst (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .rst_n         (rst_n),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hsize         (hsize),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hrdata        (hrdata),
    .hready        (hready),
    .hresp         (hresp),
    .slot0         (slot_bus[0]),
    .slot1         (slot_bus[1]),
    .slot2         (slot_bus[2]),
    .slot3         (slot_bus[3])
  );

  for (genvar s = 0; s < NUM_SLOTS; s++)
  begin : g_slot
    if (s == int'(periph_pkg::SLOT_SEG7))
    begin : g_seg7
      ahb_seg7 #(
        .SCLK_DIV (SCLK_DIV)
      ) seg7_inst (
        .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
        .rst_n         (rst_n),
        .bus           (slot_bus[s]),
        .seg7_sh_cp    (seg7_sh_cp),
        .seg7_st_cp    (seg7_st_cp),
        .seg7_ds       (seg7_ds)
      );
    end
    else
    begin : g_null
      ahb_null null_inst (         // Unused slot answers with ERROR
        .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
        .rst_n         (rst_n),
        .bus           (slot_bus[s])
      );
    end
  end

  led_flow #(
    .LED_PERIOD (LED_PERIOD)
  ) led_inst (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .rst_n         (rst_n),
    .led           (led)
  );

endmodule

//--- dv/periph_sva.sv
`timescale 1ns/100ps

module periph_sva (
  input logic       CLK_FPGA_SYS1,
  input logic       arst_n,
  input logic       rst_n,
  input logic       hready,
  input logic       hresp,
  input logic       seg7_sh_cp,
  input logic       seg7_st_cp,
  input logic [1:0] led
);

  int fail_cnt = 0;  // Failure count for the summary

  // Error response, wait cycle then completion
  err_second_cycle: assert property (@(posedge CLK_FPGA_SYS1) disable iff (!rst_n)
    (hresp && !hready) |=> (hresp && hready))
  else
  begin
    fail_cnt++;
    $error("error response did not complete in its second cycle");
  end

  no_long_wait: assert property (@(posedge CLK_FPGA_SYS1) disable iff (!rst_n)
    !hready |=> hready)
  else
  begin
    fail_cnt++;
    $error("hready low for two cycles in a row");
  end

  latch_apart: assert property (@(posedge CLK_FPGA_SYS1) disable iff (!arst_n)
    !(seg7_st_cp && seg7_sh_cp))
  else
  begin
    fail_cnt++;
    $error("storage clock high together with shift clock");
  end

  led_pattern: assert property (@(posedge CLK_FPGA_SYS1) disable iff (!arst_n)
    (led == 2'b01) || (led == 2'b10))
  else
  begin
    fail_cnt++;
    $error("led pattern is neither 01 nor 10");
  end

  // Bus quiet right after reset release
  quiet_after_reset: assert property (@(posedge CLK_FPGA_SYS1)
    $rose(rst_n) |-> (hready && !hresp) ##1 (hready && !hresp))
  else
  begin
    fail_cnt++;
    $error("bus response not idle after reset release");
  end

endmodule

bind periph_top periph_sva sva_inst (
  .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
  .arst_n        (arst_n),
  .rst_n         (rst_n),
  .hready        (hready),
  .hresp         (hresp),
  .seg7_sh_cp    (seg7_sh_cp),
  .seg7_st_cp    (seg7_st_cp),
  .led           (led)
);

//--- dv/tb_top.sv
`timescale 1ns/100ps

module tb_top;

  localparam int SCLK_DIV   = 2;
  localparam int LED_PERIOD = 20;
  localparam int TIMEOUT    = 2000;  // Cycles per wait loop
  localparam logic [31:0] SEG7_BASE = 32'h0001_0000;

  // Hex digit to segments g..a
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
    7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
    7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
    7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001
  };

  logic                CLK_FPGA_SYS1;
  logic                arst_n;
  logic                hsel;
  logic [31:0]         haddr;
  periph_pkg::htrans_e htrans;
  logic [2:0]          hsize;
  logic                hwrite;
  logic [31:0]         hwdata;
  logic [31:0]         hrdata;
  logic                hready;
  logic                hresp;
  logic                seg7_sh_cp;
  logic                seg7_st_cp;
  logic                seg7_ds;
  logic [1:0]          led;

  int          seed = 90;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  int          test_base = 0;
  logic [31:0] digits_model = '0;
  logic [7:0]  dp_model = '0;
  logic [15:0] shift_word = '0;
  logic [2:0]  scan_digit = '0;   // Next digit expected on the chain
  logic        scan_check = 1'b0;
  int          words_seen = 0;
  int          words_checked = 0;

  periph_top #(
    .SCLK_DIV   (SCLK_DIV),
    .LED_PERIOD (LED_PERIOD)
  ) UUT (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .arst_n        (arst_n),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hsize         (hsize),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hrdata        (hrdata),
    .hready        (hready),
    .hresp         (hresp),
    .seg7_sh_cp    (seg7_sh_cp),
    .seg7_st_cp    (seg7_st_cp),
    .seg7_ds       (seg7_ds),
    .led           (led)
  );

  initial CLK_FPGA_SYS1 = 1'b0;
  always #5 CLK_FPGA_SYS1 = ~CLK_FPGA_SYS1;

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp)
    else
    begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, err_cnt - test_base);
    test_base = err_cnt;
    test_cnt++;
  endtask

  // Polls hready 1 ns after each edge
  task automatic wait_ready(input string what, output int cycles);
    cycles = 0;
    while (!hready && cycles < TIMEOUT)
    begin
      @(posedge CLK_FPGA_SYS1);
      #1;
      cycles++;
    end
    if (!hready)
    begin
      $display("Timeout: hready stayed low during %s at %0t ns", what, $time);
      err_cnt++;
    end
  endtask

  // Single NONSEQ word transfer
  task automatic ahb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic resp, output int waits);
    hsel   = 1'b1;
    haddr  = addr;
    htrans = periph_pkg::NONSEQ;
    hsize  = 3'b010;
    hwrite = wr;
    wait_ready("address phase", waits);
    @(posedge CLK_FPGA_SYS1);
    #1;
    hsel   = 1'b0;
    htrans = periph_pkg::IDLE;
    hwdata = wr ? wdata : '0;
    wait_ready("data phase", waits);
    rdata = hrdata;
    resp  = hresp;
    @(posedge CLK_FPGA_SYS1);         // Data phase ends here
    #1;
  endtask

  task automatic wait_words(input int count);
    int start;
    int cycles;
    start  = words_seen;
    cycles = 0;
    while (words_seen < start + count && cycles < TIMEOUT)
    begin
      @(posedge CLK_FPGA_SYS1);
      #1;
      cycles++;
    end
    if (words_seen < start + count)
    begin
      $display("Timeout: only %0d of %0d serial words latched", words_seen - start, count);
      err_cnt++;
    end
  endtask

  task automatic wait_led_step(output int cycles);
    logic [1:0] start;
    start  = led;
    cycles = 0;
    while (led == start && cycles < TIMEOUT)
    begin
      @(posedge CLK_FPGA_SYS1);
      #1;
      cycles++;
    end
    if (led == start)
    begin
      $display("Timeout: led did not change within %0d cycles at %0t ns", TIMEOUT, $time);
      err_cnt++;
    end
  endtask

  // Segment byte dp,g..a then one-hot select
  function automatic logic [15:0] expected_word(input int k);
    logic [3:0] hex;
    hex = digits_model[4*k +: 4];
    expected_word = {dp_model[k], SEG_TABLE[hex], 8'b1 << k};
  endfunction

  always @(posedge seg7_sh_cp)
    shift_word = {shift_word[14:0], seg7_ds};

  always @(posedge seg7_st_cp)
  begin
    if (scan_check)
    begin
      check_eq($sformatf("serial word digit %0d", scan_digit),
               {16'h0, shift_word}, {16'h0, expected_word(int'(scan_digit))});
      words_checked++;
    end
    words_seen++;
    scan_digit = scan_digit + 3'd1;
  end

  initial
  begin
    logic [31:0] rd;
    logic [31:0] wdat;
    logic        rsp;
    logic [1:0]  led_prev;
    int          wt;
    int          cyc;
    int          start;
    int          i;
    int          sva_fails;

    arst_n = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    htrans = periph_pkg::IDLE;
    hsize  = 3'b010;
    hwrite = 1'b0;
    hwdata = '0;
    repeat (10) @(posedge CLK_FPGA_SYS1);
    #1;
    arst_n = 1'b1;
    repeat (4) @(posedge CLK_FPGA_SYS1);  // Past the reset synchronizer
    #1;

    check_eq("hready after reset", 32'(hready), 32'd1);
    check_eq("led after reset", 32'(led), 32'd1);
    ahb_transfer(1'b0, SEG7_BASE, '0, rd, rsp, wt);
    check_eq("DIGITS after reset", rd, 32'h0);
    ahb_transfer(1'b0, SEG7_BASE + 32'h4, '0, rd, rsp, wt);
    check_eq("DP after reset", rd, 32'h0);
    finish_test(1, "reset values");

    for (i = 0; i < 4; i++)
    begin
      wdat = $random(seed);
      digits_model = wdat;
      ahb_transfer(1'b1, SEG7_BASE, wdat, rd, rsp, wt);
      check_eq("DIGITS write hresp", 32'(rsp), 32'd0);
      ahb_transfer(1'b0, SEG7_BASE, '0, rd, rsp, wt);
      check_eq("DIGITS readback", rd, digits_model);
      check_eq("DIGITS read wait cycles", wt, 0);
      wdat = $random(seed);
      dp_model = wdat[7:0];
      ahb_transfer(1'b1, SEG7_BASE + 32'h4, wdat, rd, rsp, wt);
      ahb_transfer(1'b0, SEG7_BASE + 32'h4, '0, rd, rsp, wt);
      check_eq("DP readback", rd, {24'h0, dp_model});
      check_eq("DP read hresp", 32'(rsp), 32'd0);
    end
    wdat = $random(seed);
    ahb_transfer(1'b1, SEG7_BASE + 32'h8, wdat, rd, rsp, wt);
    ahb_transfer(1'b0, SEG7_BASE + 32'h8, '0, rd, rsp, wt);
    check_eq("unmapped offset read", rd, 32'h0);
    check_eq("unmapped offset hresp", 32'(rsp), 32'd0);
    ahb_transfer(1'b0, SEG7_BASE, '0, rd, rsp, wt);
    check_eq("DIGITS after unmapped write", rd, digits_model);
    finish_test(2, "seg7 register access");

    for (i = 0; i < 4; i++)
    begin
      if (i != 1)             // Slot 1 is the display
      begin
        wdat = $random(seed);
        ahb_transfer(1'b1, 32'(i) << 16, wdat, rd, rsp, wt);
        check_eq("null slot write hresp", 32'(rsp), 32'd1);
        check_eq("null slot write wait cycles", wt, 1);
        ahb_transfer(1'b0, (32'(i) << 16) + 32'h4, '0, rd, rsp, wt);
        check_eq("null slot read data", rd, 32'h0);
        check_eq("null slot read hresp", 32'(rsp), 32'd1);
        check_eq("null slot read wait cycles", wt, 1);
      end
    end
    finish_test(3, "null slot errors");

    for (i = 0; i < 2; i++)
    begin
      digits_model = (i == 0) ? 32'h7654_3210 : 32'hFEDC_BA98;
      wdat = $random(seed);
      dp_model = wdat[7:0];
      ahb_transfer(1'b1, SEG7_BASE, digits_model, rd, rsp, wt);
      ahb_transfer(1'b1, SEG7_BASE + 32'h4, {24'h0, dp_model}, rd, rsp, wt);
      wait_words(1);          // Word in flight may hold old values
      start = words_checked;
      scan_check = 1'b1;
      wait_words(2 * periph_pkg::NUM_DIGITS);
      scan_check = 1'b0;
      check_eq("serial words checked", words_checked - start, 2 * periph_pkg::NUM_DIGITS);
    end
    finish_test(4, "serial display scan");

    wait_led_step(cyc);
    for (i = 0; i < 4; i++)
    begin
      led_prev = led;
      wait_led_step(cyc);
      check_eq("cycles between LED steps", cyc, LED_PERIOD);
      check_eq("led after step", 32'(led), (led_prev == 2'b01) ? 32'd2 : 32'd1);
    end
    finish_test(5, "LED running light");

    sva_fails = UUT.sva_inst.fail_cnt;
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, check_cnt, err_cnt, sva_fails);
    if (err_cnt == 0 && sva_fails == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- all.f
hdl/periph_pkg.sv
hdl/ahb_if.sv
hdl/ahb_decoder.sv
hdl/seg7_shifter.sv
hdl/ahb_seg7.sv
hdl/ahb_null.sv
hdl/led_flow.sv
hdl/periph_top.sv
dv/periph_sva.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top --Mdir "$BUILD_DIR" -o tb_sim \
  -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD_DIR/tb_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
